/* bp_pkg.sv */
package bp_pkg;

  localparam int ADDR_W     = 64;  // virtual address width
  localparam int LINE_BYTES = 64;  // l1i line size
  localparam int INSTR_W    = 32;  // fixed-width a64 encoding

  // opcode patterns, matched on the top bits of each word
  localparam logic [5:0]  OP_B      = 6'b000101;       // bits 31:26
  localparam logic [5:0]  OP_BL     = 6'b100101;       // bits 31:26
  localparam logic [10:0] OP_RET_HI = 11'b11010110010; // bits 31:21
  localparam logic [7:0]  OP_BCOND  = 8'b01010100;     // bits 31:24

  typedef enum logic [1:0] {
    BR_NONE   = 2'd0,
    BR_DIRECT = 2'd1, // b or bl
    BR_RET    = 2'd2,
    BR_COND   = 2'd3
  } br_kind_e;

  // b.cond view of the info field
  typedef struct packed {
    logic [3:0] cond_code;     // instr bits 3:0
    logic       predict_taken; // gshare verdict for this slot
  } br_cond_t;

  // ret view, same five bits
  typedef struct packed {
    logic [4:0] rn; // return register, instr bits 9:5
  } br_ret_t;

  // which view applies follows from kind
  typedef union packed {
    br_cond_t cond;
    br_ret_t  ret;
  } br_info_u;

  typedef struct packed {
    logic              valid;
    br_kind_e          kind;
    logic [ADDR_W-1:0] target;
    br_info_u          info;
  } uop_branch_t;

  // room left here for a request tag
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef logic [LINE_BYTES-1:0][7:0] l1i_line_t; // byte 0 in the low bits

  // resolved branch from execute
  typedef struct packed {
    logic              valid;
    logic              mispredict;
    logic              taken;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] target;
  } resolve_t;

endpackage

/* fetch_pc_gen.sv */
module fetch_pc_gen #(
  parameter logic [bp_pkg::ADDR_W-1:0] RESET_PC = 64'h1000
) (
  input  logic                      clk_in,
  input  logic                      rst_N_in,
  input  bp_pkg::resolve_t          resolve,
  input  logic                      next_valid,
  input  logic [bp_pkg::ADDR_W-1:0] next_pc,
  input  logic                      l1i_ready,
  input  logic                      l1i_valid,
  output logic                      l1i_req_valid,
  output bp_pkg::fetch_req_t        l1i_req,
  output logic                      line_accept,
  output logic [bp_pkg::ADDR_W-1:0] fetch_addr
);
  import bp_pkg::*;

  logic              boot;        // first request still to go out
  logic              outstanding; // handshake done, line not back yet
  logic              wait_s2;     // line taken, stage 2 computing next pc
  logic              stale;       // line in flight belongs to a wrong path
  logic [ADDR_W-1:0] redir_pc;    // target parked until the stale line drains
  logic              redirect;
  logic              line_back;
  logic              in_flight;

  assign redirect  = resolve.valid && resolve.mispredict;
  assign line_back = outstanding && l1i_valid;
  assign in_flight = l1i_req_valid || (outstanding && !l1i_valid); // address committed to cache

  // a line is dropped when stale or when a redirect lands in its return cycle
  assign line_accept = line_back && !stale && !redirect;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      boot          <= 1'b1;
      l1i_req_valid <= 1'b0;
      l1i_req.addr  <= RESET_PC;
      outstanding   <= 1'b0;
      wait_s2       <= 1'b0;
      stale         <= 1'b0;
    end else if (redirect && !in_flight) begin
      // nothing owed by the cache, go straight to the target
      boot          <= 1'b0;
      l1i_req_valid <= 1'b1;
      l1i_req.addr  <= resolve.target;
      outstanding   <= 1'b0;
      wait_s2       <= 1'b0; // stage 2 next_pc is now wrong path
      stale         <= 1'b0;
    end else begin
      if (redirect) begin
        stale    <= 1'b1; // request address is frozen, drop its line instead
        redir_pc <= resolve.target;
      end
      if (boot) begin
        boot          <= 1'b0;
        l1i_req_valid <= 1'b1; // address already RESET_PC
      end
      if (l1i_req_valid && l1i_ready) begin
        l1i_req_valid <= 1'b0;
        outstanding   <= 1'b1;
        fetch_addr    <= l1i_req.addr; // held for predecode
      end
      if (line_back) begin
        outstanding <= 1'b0;
        if (stale) begin
          stale         <= 1'b0;
          l1i_req_valid <= 1'b1; // refetch from the redirect target
          l1i_req.addr  <= redir_pc;
        end else begin
          wait_s2 <= 1'b1;
        end
      end
      if (wait_s2 && next_valid) begin
        wait_s2       <= 1'b0;
        l1i_req_valid <= 1'b1;
        l1i_req.addr  <= next_pc;
      end
    end
  end

  // a request waiting on the cache keeps its address
  a_req_hold: assert property (@(posedge clk_in) disable iff (rst_N_in)
    l1i_req_valid && !l1i_ready |=> l1i_req_valid && $stable(l1i_req));

endmodule

/* line_predecode.sv */
module line_predecode #(
  parameter int SUPER_SCALAR_WIDTH = 4
) (
  input  logic                                      clk_in,
  input  logic                                      rst_N_in,
  input  logic                                      line_accept,
  input  logic [bp_pkg::ADDR_W-1:0]                 fetch_addr,
  input  bp_pkg::l1i_line_t                         l1i_line,
  output logic [bp_pkg::ADDR_W-1:0]                 dir_pc,
  input  logic                                      dir_taken,
  input  logic [bp_pkg::ADDR_W-1:0]                 ras_top,
  input  logic                                      ras_empty,
  output logic                                      ras_push,
  output logic                                      ras_pop,
  output logic [bp_pkg::ADDR_W-1:0]                 ras_push_addr,
  output logic                                      pred_valid,
  output logic [bp_pkg::ADDR_W-1:0]                 pred_pc,
  output logic [$clog2(SUPER_SCALAR_WIDTH+1)-1:0]   pc_valid_out,
  output bp_pkg::uop_branch_t [SUPER_SCALAR_WIDTH-1:0] decode_branch_data,
  output logic                                      next_valid,
  output logic [bp_pkg::ADDR_W-1:0]                 next_pc
);
  import bp_pkg::*;

  localparam int CNT_W  = $clog2(SUPER_SCALAR_WIDTH + 1);
  localparam int WORDS  = LINE_BYTES / 4;
  localparam int OFF_W  = $clog2(LINE_BYTES);
  localparam int WIDX_W = $clog2(WORDS);

  logic [WORDS-1:0][INSTR_W-1:0] words; // line viewed as instruction words
  logic [ADDR_W-1:0]  slot_pc   [SUPER_SCALAR_WIDTH];
  logic [INSTR_W-1:0] slot_word [SUPER_SCALAR_WIDTH];
  logic               slot_ok   [SUPER_SCALAR_WIDTH]; // slot still inside the line
  logic               cond_seen;
  logic               first_cond;

  uop_branch_t [SUPER_SCALAR_WIDTH-1:0] br_d;
  logic [CNT_W-1:0]  cnt_d;
  logic              taken_d;
  logic [ADDR_W-1:0] tgt_d;
  logic              push_d;
  logic              pop_d;
  logic [ADDR_W-1:0] push_addr_d;
  logic [ADDR_W-1:0] off26;
  logic [ADDR_W-1:0] off19;

  assign words = l1i_line;

  // slot extraction and gshare lookup pc, independent of dir_taken
  always_comb begin
    dir_pc    = fetch_addr;
    cond_seen = 1'b0;
    for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
      slot_pc[i]   = fetch_addr + ADDR_W'(4 * i);
      slot_ok[i]   = (int'(fetch_addr[OFF_W-1:2]) + i) < WORDS;
      slot_word[i] = words[fetch_addr[OFF_W-1:2] + WIDX_W'(i)]; // wraps, masked by slot_ok
      if (slot_ok[i] && !cond_seen && slot_word[i][31:24] == OP_BCOND) begin
        dir_pc    = slot_pc[i];
        cond_seen = 1'b1;
      end
    end
  end

  always_comb begin
    br_d        = '0;
    cnt_d       = '0;
    taken_d     = 1'b0;
    tgt_d       = '0;
    push_d      = 1'b0;
    pop_d       = 1'b0;
    push_addr_d = '0;
    off26       = '0;
    off19       = '0;
    first_cond  = 1'b1;
    for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
      if (slot_ok[i] && !taken_d) begin // group ends at first taken slot
        cnt_d = cnt_d + 1'b1;
        off26 = {{(ADDR_W-28){slot_word[i][25]}}, slot_word[i][25:0], 2'b00};
        off19 = {{(ADDR_W-21){slot_word[i][23]}}, slot_word[i][23:5], 2'b00};
        if (slot_word[i][31:26] == OP_B || slot_word[i][31:26] == OP_BL) begin
          br_d[i].valid  = 1'b1;
          br_d[i].kind   = BR_DIRECT;
          br_d[i].target = slot_pc[i] + off26;
          taken_d        = 1'b1; // unconditional
          tgt_d          = slot_pc[i] + off26;
          if (slot_word[i][31:26] == OP_BL) begin
            push_d      = 1'b1;
            push_addr_d = slot_pc[i] + ADDR_W'(4); // link address
          end
        end else if (slot_word[i][31:21] == OP_RET_HI) begin
          br_d[i].valid       = 1'b1;
          br_d[i].kind        = BR_RET;
          br_d[i].info.ret.rn = slot_word[i][9:5];
          if (!ras_empty) begin
            br_d[i].target = ras_top;
            taken_d        = 1'b1;
            tgt_d          = ras_top;
            pop_d          = 1'b1;
          end else begin
            br_d[i].target = slot_pc[i] + ADDR_W'(4); // no return known, fall through
          end
        end else if (slot_word[i][31:24] == OP_BCOND) begin
          br_d[i].valid               = 1'b1;
          br_d[i].kind                = BR_COND;
          br_d[i].target              = slot_pc[i] + off19;
          br_d[i].info.cond.cond_code = slot_word[i][3:0];
          // only the first b.cond has a table lookup, later ones assumed not taken
          br_d[i].info.cond.predict_taken = first_cond && dir_taken;
          if (first_cond && dir_taken) begin
            taken_d = 1'b1;
            tgt_d   = slot_pc[i] + off19;
          end
          first_cond = 1'b0;
        end
      end
    end
  end

  assign ras_push      = line_accept && push_d;
  assign ras_pop       = line_accept && pop_d;
  assign ras_push_addr = push_addr_d;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      pred_valid         <= 1'b0;
      decode_branch_data <= '0;
    end else begin
      pred_valid <= line_accept; // one cycle after the line
      if (line_accept) begin
        decode_branch_data <= br_d;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (line_accept) begin
      pc_valid_out <= cnt_d;
      pred_pc      <= taken_d ? tgt_d : fetch_addr + (ADDR_W'(cnt_d) << 2);
    end
  end

  assign next_valid = pred_valid; // stage 1 takes the same pulse
  assign next_pc    = pred_pc;

  // one group cannot both call and return
  a_ras_excl: assert property (@(posedge clk_in) disable iff (rst_N_in)
    !(ras_push && ras_pop));

endmodule

/* gshare_dir.sv */
module gshare_dir #(
  parameter int GHR_BITS = 8,
  parameter int PC_BITS  = 8
) (
  input  logic                      clk_in,
  input  logic                      rst_N_in,
  input  logic [bp_pkg::ADDR_W-1:0] dir_pc,
  output logic                      dir_taken,
  input  bp_pkg::resolve_t          resolve
);

  localparam int IDX_W    = GHR_BITS + PC_BITS;
  localparam int PHT_SIZE = 1 << IDX_W;

  logic [GHR_BITS-1:0] ghr;                 // newest outcome in bit 0
  logic [1:0]          pht [PHT_SIZE];      // 2-bit saturating counters
  logic [IDX_W-1:0]    lookup_idx;
  logic [IDX_W-1:0]    upd_idx;
  logic [1:0]          upd_ctr;

  // history above word-aligned pc bits
  assign lookup_idx = {ghr, dir_pc[PC_BITS+1:2]};
  assign upd_idx    = {ghr, resolve.pc[PC_BITS+1:2]};

  assign dir_taken = pht[lookup_idx][1]; // 2 or 3 means taken
  assign upd_ctr   = pht[upd_idx];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      for (int i = 0; i < PHT_SIZE; i++) begin
        pht[i] <= 2'b01; // weakly not taken
      end
    end else if (resolve.valid) begin
      if (resolve.taken && upd_ctr != 2'b11) begin
        pht[upd_idx] <= upd_ctr + 2'd1;
      end else if (!resolve.taken && upd_ctr != 2'b00) begin
        pht[upd_idx] <= upd_ctr - 2'd1;
      end
    end
  end

  // history moves after the counter is indexed with the old value
  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr <= '0;
    end else if (resolve.valid) begin
      ghr <= {ghr[GHR_BITS-2:0], resolve.taken};
    end
  end

endmodule

/* return_stack.sv */
module return_stack #(
  parameter int RAS_DEPTH = 8
) (
  input  logic                      clk_in,
  input  logic                      rst_N_in,
  input  logic                      push,
  input  logic                      pop,
  input  logic [bp_pkg::ADDR_W-1:0] push_addr,
  output logic [bp_pkg::ADDR_W-1:0] ras_top,
  output logic                      ras_empty
);
  import bp_pkg::*;

  localparam int PTR_W = $clog2(RAS_DEPTH);
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  logic [ADDR_W-1:0] mem [RAS_DEPTH];
  logic [PTR_W-1:0]  top;       // slot holding the newest entry
  logic [CNT_W-1:0]  count;     // live entries, saturates at depth
  logic [PTR_W-1:0]  top_inc;
  logic [PTR_W-1:0]  top_dec;

  // circular wrap, depth need not be a power of two
  assign top_inc = (top == PTR_W'(RAS_DEPTH - 1)) ? '0 : top + 1'b1;
  assign top_dec = (top == '0) ? PTR_W'(RAS_DEPTH - 1) : top - 1'b1;

  assign ras_top   = mem[top];
  assign ras_empty = (count == '0);

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      top   <= '0;
      count <= '0;
    end else if (push && pop) begin
      mem[top] <= push_addr; // pop then push, top replaced in place
    end else if (push) begin
      mem[top_inc] <= push_addr; // overwrites oldest when full
      top          <= top_inc;
      if (count != CNT_W'(RAS_DEPTH)) count <= count + 1'b1;
    end else if (pop && !ras_empty) begin
      top   <= top_dec;
      count <= count - 1'b1;
    end
  end

  a_count_max: assert property (@(posedge clk_in) disable iff (rst_N_in)
    count <= CNT_W'(RAS_DEPTH));

endmodule

/* branch_pred.sv */
module branch_pred #(
  parameter int                        SUPER_SCALAR_WIDTH = 4,
  parameter int                        GHR_BITS           = 8,
  parameter int                        PC_BITS            = 8,
  parameter int                        RAS_DEPTH          = 8,
  parameter logic [bp_pkg::ADDR_W-1:0] RESET_PC           = 64'h1000
) (
  input  logic                                         clk_in,
  input  logic                                         rst_N_in,
  input  logic                                         l1i_ready,
  input  logic                                         l1i_valid,
  input  bp_pkg::l1i_line_t                            l1i_line,
  input  bp_pkg::resolve_t                             resolve,
  output logic                                         l1i_req_valid,
  output bp_pkg::fetch_req_t                           l1i_req,
  output logic                                         pred_valid,
  output logic [bp_pkg::ADDR_W-1:0]                    pred_pc,
  output logic [$clog2(SUPER_SCALAR_WIDTH+1)-1:0]      pc_valid_out,
  output bp_pkg::uop_branch_t [SUPER_SCALAR_WIDTH-1:0] decode_branch_data
);
  import bp_pkg::*;

  logic              line_accept;   // stage 1 -> stage 2, good line this cycle
  logic [ADDR_W-1:0] fetch_addr;
  logic              next_valid;    // stage 2 -> stage 1
  logic [ADDR_W-1:0] next_pc;
  logic [ADDR_W-1:0] dir_pc;
  logic              dir_taken;
  logic              ras_push;
  logic              ras_pop;
  logic [ADDR_W-1:0] ras_push_addr;
  logic [ADDR_W-1:0] ras_top;
  logic              ras_empty;

  fetch_pc_gen #(
    .RESET_PC(RESET_PC)
  ) i_fetch_pc_gen (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .resolve      (resolve),
    .next_valid   (next_valid),
    .next_pc      (next_pc),
    .l1i_ready    (l1i_ready),
    .l1i_valid    (l1i_valid),
    .l1i_req_valid(l1i_req_valid),
    .l1i_req      (l1i_req),
    .line_accept  (line_accept),
    .fetch_addr   (fetch_addr)
  );

  line_predecode #(
    .SUPER_SCALAR_WIDTH(SUPER_SCALAR_WIDTH)
  ) i_line_predecode (
    .clk_in            (clk_in),
    .rst_N_in          (rst_N_in),
    .line_accept       (line_accept),
    .fetch_addr        (fetch_addr),
    .l1i_line          (l1i_line),
    .dir_pc            (dir_pc),
    .dir_taken         (dir_taken),
    .ras_top           (ras_top),
    .ras_empty         (ras_empty),
    .ras_push          (ras_push),
    .ras_pop           (ras_pop),
    .ras_push_addr     (ras_push_addr),
    .pred_valid        (pred_valid),
    .pred_pc           (pred_pc),
    .pc_valid_out      (pc_valid_out),
    .decode_branch_data(decode_branch_data),
    .next_valid        (next_valid),
    .next_pc           (next_pc)
  );

  gshare_dir #(
    .GHR_BITS(GHR_BITS),
    .PC_BITS (PC_BITS)
  ) i_gshare_dir (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .dir_pc   (dir_pc),
    .dir_taken(dir_taken),
    .resolve  (resolve)   // only b.cond resolves arrive here
  );

  return_stack #(
    .RAS_DEPTH(RAS_DEPTH)
  ) i_return_stack (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .push     (ras_push),
    .pop      (ras_pop),
    .push_addr(ras_push_addr),
    .ras_top  (ras_top),
    .ras_empty(ras_empty)
  );

endmodule

/* tb_icache_model.sv */
module tb_icache_model (
  input  logic               clk_in,
  input  logic               rst_N_in,
  input  logic               l1i_req_valid,
  input  bp_pkg::fetch_req_t l1i_req,
  output logic               l1i_ready,
  output logic               l1i_valid,
  output bp_pkg::l1i_line_t  l1i_line
);
  timeunit 1ns;
  timeprecision 100ps;
  import bp_pkg::*;

  logic [31:0]       image [logic [63:0]]; // program words by byte address
  logic [63:0]       rng = 64'd33;         // xorshift state
  logic              busy;
  int                wait_cnt;
  logic [63:0]       line_addr;
  logic              hs;
  logic              rst_s;
  logic [63:0]       req_addr;
  logic [15:0][31:0] lw;

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  task automatic load_word(input logic [63:0] addr, input logic [31:0] w);
    image[addr] = w;
  endtask

  // unprogrammed words decode as plain alu ops, top byte 0x8b
  function automatic logic [31:0] word_at(input logic [63:0] a);
    if (image.exists(a)) return image[a];
    return {8'h8b, a[23:0] ^ a[47:24] ^ {8'h00, a[63:48]}};
  endfunction

  initial begin
    l1i_ready = 1'b0;
    l1i_valid = 1'b0;
    l1i_line  = '0;
    busy      = 1'b0;
    wait_cnt  = 0;
    line_addr = '0;
  end

  always @(posedge clk_in) begin
    hs       = l1i_req_valid && l1i_ready; // handshake seen at this edge
    req_addr = l1i_req.addr;
    rst_s    = rst_N_in;
    #10;
    l1i_valid = 1'b0;
    rng       = xorshift(rng);
    if (rst_s) begin
      busy      = 1'b0;
      l1i_ready = 1'b0;
    end else begin
      if (busy) begin
        if (wait_cnt == 1) begin
          for (int j = 0; j < 16; j++) begin
            lw[j] = word_at({line_addr[63:6], 6'b0} + 64'(4 * j));
          end
          l1i_line  = lw;
          l1i_valid = 1'b1;
          busy      = 1'b0;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end
      if (hs) begin
        busy      = 1'b1;
        wait_cnt  = 1 + int'(rng[1:0]); // 1 to 4 cycles
        line_addr = req_addr;
      end
      l1i_ready = !busy && (rng[3:2] != 2'b00); // some back-pressure when idle
    end
  end

endmodule

/* tb_branch_pred.sv */
module tb_branch_pred;
  timeunit 1ns;
  timeprecision 100ps;
  import bp_pkg::*;

  localparam logic [63:0] START_PC   = 64'h1000;
  localparam int          MAX_CYCLES = 400; // about 250 needed

  logic                  clk_in;
  logic                  rst_N_in;
  logic                  l1i_ready;
  logic                  l1i_valid;
  l1i_line_t             l1i_line;
  resolve_t              resolve;
  logic                  l1i_req_valid;
  fetch_req_t            l1i_req;
  logic                  pred_valid;
  logic [63:0]           pred_pc;
  logic [2:0]            pc_valid_out;
  uop_branch_t [3:0]     decode_branch_data;

  // shadow predictor state
  logic [7:0]        s_ghr;
  logic [1:0]        s_pht [65536];
  logic [63:0]       s_ras [$];
  logic [63:0]       s_fetch_addr;
  logic              drop_pending;
  logic              exp_pending;
  logic [63:0]       exp_pc;
  logic [2:0]        exp_cnt;
  uop_branch_t [3:0] exp_br;
  logic [63:0]       exp_req_addr;
  logic              do_push;
  logic              do_pop;
  logic [63:0]       push_val;
  logic              rst_d = 1'b0;
  logic              br_valid_any;
  int                cycles = 0;
  string             test_name = "reset";

  branch_pred #(.RESET_PC(START_PC)) i_branch_pred (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .l1i_ready(l1i_ready), .l1i_valid(l1i_valid), .l1i_line(l1i_line),
    .resolve(resolve), .l1i_req_valid(l1i_req_valid), .l1i_req(l1i_req),
    .pred_valid(pred_valid), .pred_pc(pred_pc), .pc_valid_out(pc_valid_out),
    .decode_branch_data(decode_branch_data)
  );

  tb_icache_model i_icache (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .l1i_req_valid(l1i_req_valid),
    .l1i_req(l1i_req), .l1i_ready(l1i_ready), .l1i_valid(l1i_valid), .l1i_line(l1i_line)
  );

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  task automatic report_mismatch(input string what, input logic [511:0] exp_v,
                                 input logic [511:0] act_v);
    $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
    $display("TESTS FAILED");
    $fatal(1, "mismatch");
  endtask

  // expected group from the fetch rules with shadow tables read before any update
  task automatic predict_group(input logic [63:0] addr, input l1i_line_t line);
    logic [15:0][31:0] lw;
    logic [63:0]       pc;
    logic [31:0]       w;
    logic              taken;
    logic              first_cond;
    logic [63:0]       tgt;
    lw         = line;
    taken      = 1'b0;
    first_cond = 1'b1;
    tgt        = '0;
    exp_br     = '0;
    exp_cnt    = '0;
    do_push    = 1'b0;
    do_pop     = 1'b0;
    push_val   = '0;
    for (int i = 0; i < 4; i++) begin
      pc = addr + 64'(4 * i);
      if (int'(addr[5:2]) + i < 16 && !taken) begin
        w       = lw[pc[5:2]];
        exp_cnt = exp_cnt + 3'd1;
        if (w[31:26] == 6'b000101 || w[31:26] == 6'b100101) begin // b or bl
          tgt              = pc + {{36{w[25]}}, w[25:0], 2'b00};
          exp_br[i].valid  = 1'b1;
          exp_br[i].kind   = BR_DIRECT;
          exp_br[i].target = tgt;
          taken            = 1'b1;
          if (w[31]) begin
            do_push  = 1'b1;
            push_val = pc + 64'd4;
          end
        end else if (w[31:21] == 11'b11010110010) begin // ret
          exp_br[i].valid       = 1'b1;
          exp_br[i].kind        = BR_RET;
          exp_br[i].info.ret.rn = w[9:5];
          exp_br[i].target      = pc + 64'd4;
          if (s_ras.size() > 0) begin
            tgt              = s_ras[$];
            exp_br[i].target = tgt;
            taken            = 1'b1;
            do_pop           = 1'b1;
          end
        end else if (w[31:24] == 8'h54) begin // b.cond
          exp_br[i].valid               = 1'b1;
          exp_br[i].kind                = BR_COND;
          exp_br[i].target              = pc + {{43{w[23]}}, w[23:5], 2'b00};
          exp_br[i].info.cond.cond_code = w[3:0];
          exp_br[i].info.cond.predict_taken = first_cond && s_pht[{s_ghr, pc[9:2]}][1];
          if (exp_br[i].info.cond.predict_taken) begin
            taken = 1'b1;
            tgt   = exp_br[i].target;
          end
          first_cond = 1'b0;
        end
      end
    end
    exp_pc = taken ? tgt : addr + {59'b0, exp_cnt, 2'b00};
  endtask

  always @(posedge clk_in) begin
    if (rst_N_in) begin
      for (int i = 0; i < 65536; i++) s_pht[i] = 2'b01;
      s_ghr        = '0;
      s_ras.delete();
      drop_pending = 1'b0;
      exp_pending  = 1'b0;
      exp_req_addr = START_PC;
    end else begin
      exp_pending = 1'b0;
      if (l1i_valid) begin
        if (drop_pending) begin
          drop_pending = 1'b0; // wrong-path line
        end else begin
          predict_group(s_fetch_addr, l1i_line);
          exp_pending  = 1'b1;
          exp_req_addr = exp_pc;
          if (do_push) begin
            s_ras.push_back(push_val);
            if (s_ras.size() > 8) void'(s_ras.pop_front()); // oldest lost
          end
          if (do_pop) void'(s_ras.pop_back());
        end
      end
      if (resolve.valid) begin
        if (resolve.mispredict) begin
          drop_pending = 1'b1; // stimulus only redirects with a line outstanding
          exp_req_addr = resolve.target;
        end
        if (resolve.taken && s_pht[{s_ghr, resolve.pc[9:2]}] != 2'b11)
          s_pht[{s_ghr, resolve.pc[9:2]}] = s_pht[{s_ghr, resolve.pc[9:2]}] + 2'd1;
        else if (!resolve.taken && s_pht[{s_ghr, resolve.pc[9:2]}] != 2'b00)
          s_pht[{s_ghr, resolve.pc[9:2]}] = s_pht[{s_ghr, resolve.pc[9:2]}] - 2'd1;
        s_ghr = {s_ghr[6:0], resolve.taken};
      end
      if (l1i_req_valid && l1i_ready) s_fetch_addr = l1i_req.addr;
    end
    rst_d = rst_N_in;
  end

  always_comb begin
    br_valid_any = 1'b0;
    for (int i = 0; i < 4; i++) br_valid_any = br_valid_any | decode_branch_data[i].valid;
  end

  a_reset_quiet: assert property (@(posedge clk_in)
    rst_d |-> !l1i_req_valid && !pred_valid && !br_valid_any)
    else report_mismatch("outputs in reset", 3'b000,
                         {$sampled(l1i_req_valid), $sampled(pred_valid),
                          $sampled(br_valid_any)});

  // first request right after reset, later ones right after each group
  a_req_rise: assert property (@(posedge clk_in)
    pred_valid || (rst_d && !rst_N_in) |=> l1i_req_valid)
    else report_mismatch("request valid", 1'b1, $sampled(l1i_req_valid));

  a_req_addr: assert property (@(posedge clk_in) disable iff (rst_N_in)
    l1i_req_valid |-> l1i_req.addr == exp_req_addr)
    else report_mismatch("request address", $sampled(exp_req_addr), $sampled(l1i_req.addr));

  a_pred_seen: assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid == exp_pending)
    else report_mismatch("pred_valid", $sampled(exp_pending), $sampled(pred_valid));

  a_pred_pc: assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid |-> pred_pc == exp_pc)
    else report_mismatch("pred_pc", $sampled(exp_pc), $sampled(pred_pc));

  a_count: assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid |-> pc_valid_out == exp_cnt)
    else report_mismatch("pc_valid_out", $sampled(exp_cnt), $sampled(pc_valid_out));

  a_branches: assert property (@(posedge clk_in) disable iff (rst_N_in)
    pred_valid |-> decode_branch_data == exp_br)
    else report_mismatch("decode_branch_data", $sampled(exp_br), $sampled(decode_branch_data));

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout after %0d cycles in %s", MAX_CYCLES, test_name);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic wait_preds(input int n);
    repeat (n) begin
      do @(posedge clk_in); while (!pred_valid);
    end
  endtask

  // mispredict right after a handshake makes the line in flight stale
  task automatic redirect_to(input logic [63:0] target);
    do @(posedge clk_in); while (!(l1i_req_valid && l1i_ready));
    #10;
    resolve.valid      = 1'b1;
    resolve.mispredict = 1'b1;
    resolve.taken      = 1'b1;
    resolve.pc         = 64'h0;
    resolve.target     = target;
    @(posedge clk_in);
    #10 resolve = '0;
  endtask

  task automatic train_taken(input logic [63:0] pc, input int n);
    repeat (n) begin
      @(posedge clk_in);
      #10;
      resolve       = '0;
      resolve.valid = 1'b1;
      resolve.taken = 1'b1;
      resolve.pc    = pc;
    end
    @(posedge clk_in);
    #10 resolve = '0;
  endtask

  initial begin
    rst_N_in = 1'b1;
    resolve  = '0;
    i_icache.load_word(64'h3008, 32'h14000040); // b to 0x3108
    i_icache.load_word(64'h3110, 32'h940003bc); // bl to 0x4000
    i_icache.load_word(64'h4008, 32'hd65f03c0); // ret x30
    i_icache.load_word(64'h5004, 32'h54000201); // b.ne to 0x5044
    i_icache.load_word(64'h6004, 32'h17fffffc); // b back to 0x5ff4
    repeat (5) @(posedge clk_in);
    #10 rst_N_in = 1'b0;
    test_name = "sequential";
    wait_preds(4);
    redirect_to(64'h2038); // two slots left in the line
    wait_preds(2);
    test_name = "b_bl";
    redirect_to(64'h3000);
    wait_preds(2);
    test_name = "bl_ret";
    wait_preds(3);
    test_name = "bcond";
    redirect_to(64'h5000);
    wait_preds(2);
    train_taken(64'h5004, 12);
    redirect_to(64'h5000);
    wait_preds(2);
    test_name = "mispredict";
    redirect_to(64'h6000);
    wait_preds(3);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* branch_pred.f */
bp_pkg.sv
fetch_pc_gen.sv
line_predecode.sv
gshare_dir.sv
return_stack.sv
branch_pred.sv
tb_icache_model.sv
tb_branch_pred.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_branch_pred \
  -f branch_pred.f -o sim_tb || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
